/* verilog/mem_pkg.sv */
/*
 * Shared widths, busy count and access size encoding for the memory side
 * Vector typedefs and the arbiter state enum
 */

package mem_pkg;

  // ************************************************************
  // Widths
  // ************************************************************
  localparam int ADDR_SIZE = 8;
  localparam int BYTE_SIZE = 8;
  localparam int DATA_SIZE = 32;
  localparam int LANES = DATA_SIZE / BYTE_SIZE;
  localparam int RAM_DEPTH = 2 ** ADDR_SIZE;

  // Cycles with ACK low after an accepted strobe
  localparam int BUSY_CYCLES = 3;
  localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

  // ************************************************************
  // Types
  // ************************************************************
  typedef logic [ADDR_SIZE-1:0] addr_t;
  typedef logic [DATA_SIZE-1:0] data_t;
  typedef logic [LANES-1:0] sel_t;
  typedef logic [BUSY_W-1:0] busy_cnt_t;

  // Access size where value 3 is illegal
  typedef logic [1:0] mem_size_t;
  localparam mem_size_t SIZE_BYTE = 2'd0;
  localparam mem_size_t SIZE_HALF = 2'd1;
  localparam mem_size_t SIZE_WORD = 2'd2;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_STROBE,
    ARB_BUSY,
    ARB_DONE
  } arb_state_t;

endpackage

/* verilog/load_store_align.sv */
/*
 * Size decode into byte lane enables
 * Zero or sign extension of loaded bytes and halfwords
 */

module load_store_align (
  input  mem_pkg::mem_size_t ls_size,
  input  logic               ls_unsigned,
  output mem_pkg::sel_t      data_sel,
  input  mem_pkg::data_t     data_rdata,
  output mem_pkg::data_t     ls_rdata
);

  localparam int BW = mem_pkg::BYTE_SIZE;
  localparam int HW = 2 * mem_pkg::BYTE_SIZE;

  logic byte_sign;
  logic half_sign;

  // Fill bit is zero for unsigned loads
  assign byte_sign = !ls_unsigned && data_rdata[BW-1];
  assign half_sign = !ls_unsigned && data_rdata[HW-1];

  // ************************************************************
  // Lane enables
  // ************************************************************
  always_comb begin
    case (ls_size)
      mem_pkg::SIZE_BYTE: data_sel = 4'b0001;
      mem_pkg::SIZE_HALF: data_sel = 4'b0011;
      mem_pkg::SIZE_WORD: data_sel = 4'b1111;
      // Illegal size enables nothing
      default:            data_sel = '0;
    endcase
  end

  // ************************************************************
  // Load extension
  // ************************************************************
  always_comb begin
    case (ls_size)
      mem_pkg::SIZE_BYTE: begin
        ls_rdata = {{(mem_pkg::DATA_SIZE-BW){byte_sign}}, data_rdata[BW-1:0]};
      end
      mem_pkg::SIZE_HALF: begin
        ls_rdata = {{(mem_pkg::DATA_SIZE-HW){half_sign}}, data_rdata[HW-1:0]};
      end
      default: begin
        ls_rdata = data_rdata;
      end
    endcase
  end

endmodule

/* verilog/mem_arbiter.sv */
/*
 * Fixed-priority arbiter between load/store and fetch
 * One access in flight, strobe issue and per-port done pulses
 */

module mem_arbiter (
  input  logic           CLK_I,
  input  logic           rst_n,
  // Fetch port
  input  logic           fetch_req,
  input  mem_pkg::addr_t fetch_adr,
  output logic           fetch_done,
  output mem_pkg::data_t fetch_data,
  // Load/store port
  input  logic           data_req,
  input  logic           data_we,
  input  mem_pkg::addr_t data_adr,
  input  mem_pkg::sel_t  data_sel,
  input  mem_pkg::data_t data_wdata,
  output logic           data_done,
  output mem_pkg::data_t data_rdata,
  // RAM side
  output logic           ram_stb,
  output logic           ram_we,
  output mem_pkg::addr_t ram_adr,
  output mem_pkg::sel_t  ram_sel,
  output mem_pkg::data_t ram_wdata,
  input  mem_pkg::data_t ram_rdata,
  input  logic           ram_ack
);

  mem_pkg::arb_state_t state;
  mem_pkg::arb_state_t state_next;

  logic           sample;
  logic           grant_ls;
  logic           acc_we;
  mem_pkg::addr_t acc_adr;
  mem_pkg::sel_t  acc_sel;
  mem_pkg::data_t acc_wdata;

  assign sample = (state == mem_pkg::ARB_IDLE) && ram_ack && (data_req || fetch_req);

  // ************************************************************
  // FSM
  // ************************************************************
  always_comb begin
    state_next = state;
    case (state)
      mem_pkg::ARB_IDLE: begin
        if (sample) begin
          state_next = mem_pkg::ARB_STROBE;
        end
      end
      mem_pkg::ARB_STROBE: state_next = mem_pkg::ARB_BUSY;
      mem_pkg::ARB_BUSY: begin
        if (ram_ack) begin
          state_next = mem_pkg::ARB_DONE;
        end
      end
      default: state_next = mem_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mem_pkg::ARB_IDLE;
      grant_ls <= 1'b0;
    end else begin
      state <= state_next;
      // Load/store wins when both ask
      if (sample) begin
        grant_ls <= data_req;
      end
    end
  end

  // Latch the granted access
  always_ff @(posedge CLK_I) begin
    if (sample) begin
      if (data_req) begin
        acc_we    <= data_we;
        acc_adr   <= data_adr;
        acc_sel   <= data_sel;
        acc_wdata <= data_wdata;
      end else begin
        acc_we    <= 1'b0;
        acc_adr   <= fetch_adr;
        acc_sel   <= '1;
        acc_wdata <= '0;
      end
    end
  end

  assign ram_stb   = (state == mem_pkg::ARB_STROBE);
  assign ram_we    = acc_we;
  assign ram_adr   = acc_adr;
  assign ram_sel   = acc_sel;
  assign ram_wdata = acc_wdata;

  // ************************************************************
  // Completion
  // ************************************************************
  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      fetch_done <= 1'b0;
      data_done  <= 1'b0;
    end else begin
      fetch_done <= (state == mem_pkg::ARB_DONE) && !grant_ls;
      data_done  <= (state == mem_pkg::ARB_DONE) && grant_ls;
    end
  end

  // Read data lands together with the done pulse
  always_ff @(posedge CLK_I) begin
    if (state == mem_pkg::ARB_DONE) begin
      if (!grant_ls) begin
        fetch_data <= ram_rdata;
      end else if (!acc_we) begin
        data_rdata <= ram_rdata;
      end
    end
  end

  a_stb_single : assert property (
    @(posedge CLK_I) disable iff (!rst_n)
    ram_stb |-> ram_ack ##1 !ram_stb
  );

  // RAM goes busy after every strobe it was given
  a_stb_accepted : assert property (
    @(posedge CLK_I) disable iff (!rst_n)
    ram_stb |=> !ram_ack
  );

  // Lane mask from the size decoder reflects a legal size
  a_size_legal : assert property (
    @(posedge CLK_I) disable iff (!rst_n)
    data_req |-> data_sel inside {4'b0001, 4'b0011, 4'b1111}
  );

endmodule

/* verilog/single_port_ram.sv */
/*
 * Byte-enabled single port RAM with synchronous write and registered read
 * Fixed busy period signalled through ACK_O
 */

module single_port_ram (
  input  logic           CLK_I,
  input  logic           rst_n,
  input  logic           STB_I,
  input  logic           WE_I,
  input  mem_pkg::addr_t ADR_I,
  input  mem_pkg::data_t DAT_I,
  input  mem_pkg::sel_t  SEL_I,
  output mem_pkg::data_t DAT_O,
  output logic           ACK_O
);

  logic [mem_pkg::BYTE_SIZE-1:0] mem [mem_pkg::RAM_DEPTH];

  // Per-lane byte address wrapping at the top of the array
  mem_pkg::addr_t lane_adr [mem_pkg::LANES];

  mem_pkg::busy_cnt_t busy_cnt;

  always_comb begin
    for (int i = 0; i < mem_pkg::LANES; i++) begin
      lane_adr[i] = ADR_I + mem_pkg::addr_t'(i);
    end
  end

  // ************************************************************
  // Storage
  // ************************************************************

  // Lane-wise write
  always_ff @(posedge CLK_I) begin
    if (STB_I && WE_I) begin
      for (int i = 0; i < mem_pkg::LANES; i++) begin
        if (SEL_I[i]) begin
          mem[lane_adr[i]] <= DAT_I[i*mem_pkg::BYTE_SIZE +: mem_pkg::BYTE_SIZE];
        end
      end
    end
  end

  // Registered read with disabled lanes cleared
  always_ff @(posedge CLK_I) begin
    if (STB_I && !WE_I) begin
      for (int i = 0; i < mem_pkg::LANES; i++) begin
        if (SEL_I[i]) begin
          DAT_O[i*mem_pkg::BYTE_SIZE +: mem_pkg::BYTE_SIZE] <= mem[lane_adr[i]];
        end else begin
          DAT_O[i*mem_pkg::BYTE_SIZE +: mem_pkg::BYTE_SIZE] <= '0;
        end
      end
    end
  end

  // ************************************************************
  // Busy counter
  // ************************************************************
  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      busy_cnt <= '0;
    end else if (STB_I) begin
      busy_cnt <= mem_pkg::busy_cnt_t'(mem_pkg::BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign ACK_O = (busy_cnt == '0);

  // Strobes only land on an idle RAM
  a_stb_when_ready : assert property (
    @(posedge CLK_I) disable iff (!rst_n)
    STB_I |-> ACK_O
  );

endmodule

/* verilog/mem_subsystem.sv */
/*
 * Memory subsystem top
 * Alignment, arbiter and byte-enabled RAM
 */

module mem_subsystem (
  input  logic               CLK_I,
  input  logic               rst_n,
  // Fetch port
  input  logic               fetch_req,
  input  mem_pkg::addr_t     fetch_adr,
  output logic               fetch_done,
  output mem_pkg::data_t     fetch_data,
  // Load/store port
  input  logic               ls_req,
  input  logic               ls_we,
  input  mem_pkg::mem_size_t ls_size,
  input  logic               ls_unsigned,
  input  mem_pkg::addr_t     ls_adr,
  input  mem_pkg::data_t     ls_wdata,
  output logic               ls_done,
  output mem_pkg::data_t     ls_rdata
);

  mem_pkg::sel_t  data_sel;
  mem_pkg::data_t data_rdata;

  logic           ram_stb;
  logic           ram_we;
  mem_pkg::addr_t ram_adr;
  mem_pkg::sel_t  ram_sel;
  mem_pkg::data_t ram_wdata;
  mem_pkg::data_t ram_rdata;
  logic           ram_ack;

  load_store_align i_align (
    .ls_size     (ls_size),
    .ls_unsigned (ls_unsigned),
    .data_sel    (data_sel),
    .data_rdata  (data_rdata),
    .ls_rdata    (ls_rdata)
  );

  mem_arbiter i_arbiter (
    .CLK_I      (CLK_I),
    .rst_n      (rst_n),
    .fetch_req  (fetch_req),
    .fetch_adr  (fetch_adr),
    .fetch_done (fetch_done),
    .fetch_data (fetch_data),
    .data_req   (ls_req),
    .data_we    (ls_we),
    .data_adr   (ls_adr),
    .data_sel   (data_sel),
    .data_wdata (ls_wdata),
    .data_done  (ls_done),
    .data_rdata (data_rdata),
    .ram_stb    (ram_stb),
    .ram_we     (ram_we),
    .ram_adr    (ram_adr),
    .ram_sel    (ram_sel),
    .ram_wdata  (ram_wdata),
    .ram_rdata  (ram_rdata),
    .ram_ack    (ram_ack)
  );

  single_port_ram i_ram (
    .CLK_I (CLK_I),
    .rst_n (rst_n),
    .STB_I (ram_stb),
    .WE_I  (ram_we),
    .ADR_I (ram_adr),
    .DAT_I (ram_wdata),
    .SEL_I (ram_sel),
    .DAT_O (ram_rdata),
    .ACK_O (ram_ack)
  );

endmodule

/* verif/mem_tb_tests.svh */
/*
 * Directed tests for the memory subsystem testbench
 * Word path, sub-word merge and extension, wrap, contention, random mix
 */

task automatic test_reset_word();
  start_test("reset_word");
  check_eq("ls_done after reset", '0, mem_pkg::data_t'(ls_done));
  check_eq("fetch_done after reset", '0, mem_pkg::data_t'(fetch_done));
  store(mem_pkg::SIZE_WORD, 8'h10, 32'hdeadbeef);
  load_check(mem_pkg::SIZE_WORD, 1'b0, 8'h10);
  fetch_check(8'h10);
  end_test();
endtask

task automatic test_sub_word();
  start_test("sub_word");
  store(mem_pkg::SIZE_WORD, 8'h20, 32'h01234567);
  // Byte with its top bit set and a halfword over the upper two bytes
  store(mem_pkg::SIZE_BYTE, 8'h21, 32'h5555559c);
  store(mem_pkg::SIZE_HALF, 8'h22, 32'haaaaf00d);
  fetch_check(8'h20);
  load_check(mem_pkg::SIZE_BYTE, 1'b0, 8'h21);
  load_check(mem_pkg::SIZE_BYTE, 1'b1, 8'h21);
  load_check(mem_pkg::SIZE_HALF, 1'b0, 8'h22);
  load_check(mem_pkg::SIZE_HALF, 1'b1, 8'h22);
  load_check(mem_pkg::SIZE_BYTE, 1'b0, 8'h20);
  load_check(mem_pkg::SIZE_HALF, 1'b1, 8'h20);
  end_test();
endtask

task automatic test_unaligned();
  start_test("unaligned");
  // Known neighbours first
  store(mem_pkg::SIZE_WORD, 8'h40, fill_word(8'h40));
  store(mem_pkg::SIZE_WORD, 8'h44, fill_word(8'h44));
  store(mem_pkg::SIZE_WORD, 8'h41, 32'ha1b2c3d4);
  load_check(mem_pkg::SIZE_WORD, 1'b0, 8'h41);
  fetch_check(8'h40);
  fetch_check(8'h44);
  // Word across the top of the RAM
  store(mem_pkg::SIZE_WORD, 8'd252, fill_word(8'd252));
  store(mem_pkg::SIZE_WORD, 8'd0, fill_word(8'd0));
  store(mem_pkg::SIZE_WORD, 8'd254, 32'h5e6f7a8b);
  load_check(mem_pkg::SIZE_WORD, 1'b0, 8'd254);
  fetch_check(8'd252);
  fetch_check(8'd0);
  end_test();
endtask

task automatic test_contention();
  mem_pkg::data_t ls_rd;
  mem_pkg::data_t f_rd;
  int             ls_cyc;
  int             f_cyc;
  start_test("contention");
  store(mem_pkg::SIZE_WORD, 8'h80, 32'h0badf00d);
  // Store and fetch on the same word with the store served first
  fork
    ls_access(1'b1, mem_pkg::SIZE_WORD, 1'b0, 8'h80, 32'hcafe0001, ls_rd, ls_cyc);
    fetch_access(8'h80, f_rd, f_cyc);
  join
  model_store(mem_pkg::SIZE_WORD, 8'h80, 32'hcafe0001);
  check_eq("ls_done ahead of fetch_done", 32'd1, mem_pkg::data_t'(ls_cyc < f_cyc));
  check_eq("fetch after store", model_load(mem_pkg::SIZE_WORD, 1'b1, 8'h80), f_rd);
  fork
    ls_access(1'b0, mem_pkg::SIZE_BYTE, 1'b0, 8'h83, '0, ls_rd, ls_cyc);
    fetch_access(8'h10, f_rd, f_cyc);
  join
  check_eq("ls_done ahead of fetch_done", 32'd1, mem_pkg::data_t'(ls_cyc < f_cyc));
  check_eq("signed byte load", model_load(mem_pkg::SIZE_BYTE, 1'b0, 8'h83), ls_rd);
  check_eq("fetch beside load", model_load(mem_pkg::SIZE_WORD, 1'b1, 8'h10), f_rd);
  end_test();
endtask

task automatic test_random();
  logic               is_fetch;
  logic               we;
  mem_pkg::mem_size_t size;
  logic               uns;
  mem_pkg::addr_t     adr;
  mem_pkg::data_t     wdata;
  start_test("random");
  // Whole RAM gets known contents
  for (int a = 0; a < mem_pkg::RAM_DEPTH; a += 4) begin
    store(mem_pkg::SIZE_WORD, mem_pkg::addr_t'(a), fill_word(mem_pkg::addr_t'(a)));
  end
  repeat (200) begin
    is_fetch = 1'(rand_bits(1));
    we       = 1'(rand_bits(1));
    size     = mem_pkg::mem_size_t'(rand_bits(2));
    if (size == 2'd3) size = mem_pkg::SIZE_WORD;
    uns      = 1'(rand_bits(1));
    adr      = mem_pkg::addr_t'(rand_bits(8));
    wdata    = rand_bits(32);
    if (is_fetch) begin
      fetch_check(adr);
    end else if (we) begin
      store(size, adr, wdata);
    end else begin
      load_check(size, uns, adr);
    end
  end
  end_test();
endtask

/* verif/mem_tb.sv */
/*
 * Testbench top for the memory subsystem
 * Clock, reset, DUT, LFSR, byte-array reference model, port tasks and summary
 */

module mem_tb;

  // Twice the expected work of about 250 accesses at about 8 cycles each
  localparam int EST_ACCESSES = 250;
  localparam int EST_CYCLES_PER_ACCESS = 8;
  localparam int TIMEOUT_CYCLES = 2 * EST_ACCESSES * EST_CYCLES_PER_ACCESS;

  logic               CLK_I;
  logic               rst_n;
  logic               fetch_req;
  mem_pkg::addr_t     fetch_adr;
  logic               fetch_done;
  mem_pkg::data_t     fetch_data;
  logic               ls_req;
  logic               ls_we;
  mem_pkg::mem_size_t ls_size;
  logic               ls_unsigned;
  mem_pkg::addr_t     ls_adr;
  mem_pkg::data_t     ls_wdata;
  logic               ls_done;
  mem_pkg::data_t     ls_rdata;

  // Reference model of the RAM contents
  logic [mem_pkg::BYTE_SIZE-1:0] model_mem [mem_pkg::RAM_DEPTH];

  logic [31:0] lfsr_state = 32'h64dec1ce;
  int          cycles;
  int          error_count = 0;
  int          check_count = 0;
  int          tests_run = 0;
  int          test_start_errors = 0;
  string       test_name = "";

  mem_subsystem i_dut (
    .CLK_I       (CLK_I),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_adr   (fetch_adr),
    .fetch_done  (fetch_done),
    .fetch_data  (fetch_data),
    .ls_req      (ls_req),
    .ls_we       (ls_we),
    .ls_size     (ls_size),
    .ls_unsigned (ls_unsigned),
    .ls_adr      (ls_adr),
    .ls_wdata    (ls_wdata),
    .ls_done     (ls_done),
    .ls_rdata    (ls_rdata)
  );

  initial begin
    CLK_I = 1'b0;
    forever #5 CLK_I = ~CLK_I;
  end

  // Watchdog that owns the cycle counter
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK_I);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

  // ************************************************************
  // Random numbers and reference model
  // ************************************************************

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_next_bit()};
    end
    return value;
  endfunction

  function automatic int lane_count(mem_pkg::mem_size_t size);
    case (size)
      mem_pkg::SIZE_BYTE: return 1;
      mem_pkg::SIZE_HALF: return 2;
      default:            return 4;
    endcase
  endfunction

  function automatic void model_store(mem_pkg::mem_size_t size, mem_pkg::addr_t adr,
                                      mem_pkg::data_t data);
    for (int i = 0; i < lane_count(size); i++) begin
      model_mem[mem_pkg::addr_t'(adr + i)] = data[i*8 +: 8];
    end
  endfunction

  function automatic mem_pkg::data_t model_load(mem_pkg::mem_size_t size, logic uns,
                                                mem_pkg::addr_t adr);
    mem_pkg::data_t raw;
    raw = '0;
    for (int i = 0; i < lane_count(size); i++) begin
      raw[i*8 +: 8] = model_mem[mem_pkg::addr_t'(adr + i)];
    end
    if (!uns && lane_count(size) == 1 && raw[7]) raw[31:8] = '1;
    if (!uns && lane_count(size) == 2 && raw[15]) raw[31:16] = '1;
    return raw;
  endfunction

  // Fill value that differs for every byte address
  function automatic mem_pkg::data_t fill_word(mem_pkg::addr_t adr);
    mem_pkg::data_t w;
    for (int i = 0; i < 4; i++) begin
      w[i*8 +: 8] = mem_pkg::addr_t'(adr + i) * 8'd37 + 8'h1b;
    end
    return w;
  endfunction

  // ************************************************************
  // Checking and port tasks
  // ************************************************************
  task automatic check_eq(string what, mem_pkg::data_t expected, mem_pkg::data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: %s, expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_start_errors = error_count;
    tests_run++;
  endtask

  task automatic end_test();
    if (error_count == test_start_errors) begin
      $display("%s: passed", test_name);
    end else begin
      $display("%s: %0d mismatches", test_name, error_count - test_start_errors);
    end
  endtask

  task automatic ls_access(input logic we, input mem_pkg::mem_size_t size, input logic uns,
                           input mem_pkg::addr_t adr, input mem_pkg::data_t wdata,
                           output mem_pkg::data_t rdata, output int done_cycle);
    @(negedge CLK_I);
    ls_req      = 1'b1;
    ls_we       = we;
    ls_size     = size;
    ls_unsigned = uns;
    ls_adr      = adr;
    ls_wdata    = wdata;
    do begin
      @(negedge CLK_I);
    end while (!ls_done);
    rdata      = ls_rdata;
    done_cycle = cycles;
    ls_req     = 1'b0;
  endtask

  task automatic fetch_access(input mem_pkg::addr_t adr, output mem_pkg::data_t rdata,
                              output int done_cycle);
    @(negedge CLK_I);
    fetch_req = 1'b1;
    fetch_adr = adr;
    do begin
      @(negedge CLK_I);
    end while (!fetch_done);
    rdata      = fetch_data;
    done_cycle = cycles;
    fetch_req  = 1'b0;
  endtask

  task automatic store(mem_pkg::mem_size_t size, mem_pkg::addr_t adr, mem_pkg::data_t wdata);
    mem_pkg::data_t unused;
    int             cyc;
    ls_access(1'b1, size, 1'b0, adr, wdata, unused, cyc);
    model_store(size, adr, wdata);
  endtask

  task automatic load_check(mem_pkg::mem_size_t size, logic uns, mem_pkg::addr_t adr);
    mem_pkg::data_t rd;
    int             cyc;
    ls_access(1'b0, size, uns, adr, '0, rd, cyc);
    check_eq($sformatf("load size %0d unsigned %0b at %h", size, uns, adr),
             model_load(size, uns, adr), rd);
  endtask

  task automatic fetch_check(mem_pkg::addr_t adr);
    mem_pkg::data_t rd;
    int             cyc;
    fetch_access(adr, rd, cyc);
    check_eq($sformatf("fetch at %h", adr), model_load(mem_pkg::SIZE_WORD, 1'b1, adr), rd);
  endtask

  `include "mem_tb_tests.svh"

  initial begin
    rst_n       = 1'b0;
    fetch_req   = 1'b0;
    fetch_adr   = '0;
    ls_req      = 1'b0;
    ls_we       = 1'b0;
    ls_size     = mem_pkg::SIZE_WORD;
    ls_unsigned = 1'b0;
    ls_adr      = '0;
    ls_wdata    = '0;
    repeat (5) @(negedge CLK_I);
    rst_n = 1'b1;

    test_reset_word();
    test_sub_word();
    test_unaligned();
    test_contention();
    test_random();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
             error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+verif
verilog/mem_pkg.sv
verilog/load_store_align.sv
verilog/mem_arbiter.sv
verilog/single_port_ram.sv
verilog/mem_subsystem.sv
verif/mem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/load_store_align.sv
      - verilog/mem_arbiter.sv
      - verilog/single_port_ram.sv
      - verilog/mem_subsystem.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/mem_tb.sv
